//--- Bender.yml
package:
  name: host_chan

sources:
  - host_chan_pkg.sv
  - fim_to_pim_stream_map.sv
  - tlp_tx_steer.sv
  - wr_commit_tracker.sv
  - host_chan_top.sv
  - target: simulation
    files:
      - tb_host_chan.sv

//--- fim_to_pim_stream_map.sv
module fim_to_pim_stream_map
(
    input  logic                    clk,
    input  logic                    reset_n,

    // Transmit streams from the steering stage, platform format
    input  logic                    pim_tx_a_valid,
    input  host_chan_pkg::pim_beat_t pim_tx_a,
    output logic                    pim_tx_a_ready,
    input  logic                    pim_tx_b_valid,
    input  host_chan_pkg::pim_beat_t pim_tx_b,
    output logic                    pim_tx_b_ready,

    // Transmit streams toward the PCIe subsystem
    output logic                    fim_tx_a_valid,
    output host_chan_pkg::fim_beat_t fim_tx_a,
    input  logic                    fim_tx_a_ready,
    output logic                    fim_tx_b_valid,
    output host_chan_pkg::fim_beat_t fim_tx_b,
    input  logic                    fim_tx_b_ready,

    // Receive streams from the PCIe subsystem
    input  logic                    fim_rx_a_valid,
    input  host_chan_pkg::fim_beat_t fim_rx_a,
    output logic                    fim_rx_a_ready,
    input  logic                    fim_rx_b_valid,
    input  host_chan_pkg::fim_beat_t fim_rx_b,
    output logic                    fim_rx_b_ready,

    // Receive streams toward the accelerator, platform format
    output logic                    afu_rx_a_valid,
    output host_chan_pkg::pim_beat_t afu_rx_a,
    input  logic                    afu_rx_a_ready,
    output logic                    afu_rx_b_valid,
    output host_chan_pkg::pim_beat_t afu_rx_b,
    input  logic                    afu_rx_b_ready
);

    import host_chan_pkg::*;

    // Set while the next receive A beat opens a new packet
    logic rx_a_sop_q;

    // Platform to subsystem beat, shared by both transmit channels
    function automatic fim_beat_t tx_to_fim(input pim_beat_t b);
        fim_beat_t f;
        f.data = b.data;
        f.last = b.last;
        // Masks are dword granular, so each nibble follows the first byte of its dword
        for (int w = 0; w < TDATA_WIDTH / 32; w++)
        begin
            f.keep[w*4 +: 4] = {4{b.keep[w*4]}};
        end
        // Only segment 0 carries a header, so its format flag speaks for the beat
        f.tuser_vendor = '0;
        f.tuser_vendor[0] = b.user[0].dm_mode;
        return f;
    endfunction

    // Subsystem to platform beat without the packet flags
    function automatic pim_beat_t rx_to_pim(input fim_beat_t f);
        pim_beat_t b;
        b.data = f.data;
        b.keep = f.keep;
        b.last = f.last;
        b.user = '0;
        b.user[0].dm_mode = f.tuser_vendor[0];
        return b;
    endfunction

    // Handshakes pass straight through in both directions
    assign fim_tx_a_valid = pim_tx_a_valid;
    assign pim_tx_a_ready = fim_tx_a_ready;
    assign fim_tx_b_valid = pim_tx_b_valid;
    assign pim_tx_b_ready = fim_tx_b_ready;
    assign afu_rx_a_valid = fim_rx_a_valid;
    assign fim_rx_a_ready = afu_rx_a_ready;
    assign afu_rx_b_valid = fim_rx_b_valid;
    assign fim_rx_b_ready = afu_rx_b_ready;

    assign fim_tx_a = tx_to_fim(pim_tx_a);
    assign fim_tx_b = tx_to_fim(pim_tx_b);

    always_comb
    begin
        afu_rx_a = rx_to_pim(fim_rx_a);
        afu_rx_a.user[0].sop = rx_a_sop_q;
        // End of packet is flagged once, and only on a beat that holds a payload segment
        for (int s = 0; s < NUM_OF_SEG; s++)
        begin
            if (fim_rx_a.keep[s*SEG_BYTES])
            begin
                afu_rx_a.user[0].eop = fim_rx_a.last;
            end
        end
    end

    // Completions on receive B have no payload, so every beat opens and closes a packet
    always_comb
    begin
        afu_rx_b = rx_to_pim(fim_rx_b);
        afu_rx_b.user[0].sop = fim_rx_b.last;
        afu_rx_b.user[0].eop = fim_rx_b.last;
    end

    // The beat after a last beat starts the next packet
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rx_a_sop_q <= 1'b1;
        end
        else if (fim_rx_a_valid && fim_rx_a_ready)
        begin
            rx_a_sop_q <= fim_rx_a.last;
        end
    end

    // The subsystem never splits a write completion over more than one beat
    a_rx_b_single_beat : assert property (
        @(posedge clk) disable iff (!reset_n)
        (fim_rx_b_valid && fim_rx_b_ready) |-> fim_rx_b.last
    );

endmodule

//--- host_chan_pkg.sv
package host_chan_pkg;

    // Geometry of one stream beat on both sides of the adapter
    localparam int TDATA_WIDTH = 256;
    localparam int NUM_OF_SEG = 2;

    // Bytes in one segment, used to find the first keep bit of each segment
    localparam int SEG_BYTES = TDATA_WIDTH / NUM_OF_SEG / 8;

    // Format and type byte of a TLP header
    // Memory requests use the 4DW form since the header carries a 64 bit address
    typedef enum logic [7:0] {
        MEM_RD = 8'h20,
        MEM_WR = 8'h60,
        CPL    = 8'h0a,
        CPLD   = 8'h4a,
        MSG    = 8'h30
    } tlp_op_e;

    // Request header as it sits in segment 0 of the first beat of a packet
    // The first field is the most significant one
    typedef struct packed {
        tlp_op_e      fmt_type;
        logic [9:0]   length;
        logic [9:0]   tag;
        logic [2:0]   pf_num;
        logic [10:0]  vf_num;
        logic         vf_active;
        logic [63:0]  addr;
        logic [20:0]  reserved;
    } tlp_req_hdr_t;

    // Per-segment user bits of the platform stream
    typedef struct packed {
        // Data mover format when set, power user format when clear
        logic dm_mode;
        logic sop;
        logic eop;
    } seg_user_t;

    // One beat of the platform stream seen by the accelerator
    typedef struct packed {
        logic [TDATA_WIDTH-1:0]            data;
        logic [TDATA_WIDTH/8-1:0]          keep;
        logic                              last;
        seg_user_t [NUM_OF_SEG-1:0]        user;
    } pim_beat_t;

    // One beat of the subsystem stream
    typedef struct packed {
        logic [TDATA_WIDTH-1:0]            data;
        logic [TDATA_WIDTH/8-1:0]          keep;
        logic                              last;
        // Bit 0 carries the data mover format flag, the rest is unused here
        logic [9:0]                        tuser_vendor;
    } fim_beat_t;

endpackage

//--- host_chan_top.sv
module host_chan_top
#(
    parameter logic [2:0]  PF_NUM    = 3'd2,
    parameter logic [10:0] VF_NUM    = 11'd5,
    parameter logic        VF_ACTIVE = 1'b1,
    parameter int          CNT_WIDTH = 8
)
(
    input  logic                     clk,
    input  logic                     reset_n,

    // Accelerator transmit stream
    input  logic                     afu_tx_valid,
    input  host_chan_pkg::pim_beat_t afu_tx,
    output logic                     afu_tx_ready,

    // Subsystem transmit channels
    output logic                     fim_tx_a_valid,
    output host_chan_pkg::fim_beat_t fim_tx_a,
    input  logic                     fim_tx_a_ready,
    output logic                     fim_tx_b_valid,
    output host_chan_pkg::fim_beat_t fim_tx_b,
    input  logic                     fim_tx_b_ready,

    // Subsystem receive channels
    input  logic                     fim_rx_a_valid,
    input  host_chan_pkg::fim_beat_t fim_rx_a,
    output logic                     fim_rx_a_ready,
    input  logic                     fim_rx_b_valid,
    input  host_chan_pkg::fim_beat_t fim_rx_b,
    output logic                     fim_rx_b_ready,

    // Accelerator receive streams
    output logic                     afu_rx_a_valid,
    output host_chan_pkg::pim_beat_t afu_rx_a,
    input  logic                     afu_rx_a_ready,
    output logic                     afu_rx_b_valid,
    output host_chan_pkg::pim_beat_t afu_rx_b,
    input  logic                     afu_rx_b_ready,

    output logic [CNT_WIDTH-1:0]     wr_outstanding
);

    import host_chan_pkg::*;

    // Steered transmit streams, still in platform format
    logic      pim_tx_a_valid;
    pim_beat_t pim_tx_a;
    logic      pim_tx_a_ready;
    logic      pim_tx_b_valid;
    pim_beat_t pim_tx_b;
    logic      pim_tx_b_ready;

    tlp_tx_steer
    #(
        .PF_NUM    (PF_NUM),
        .VF_NUM    (VF_NUM),
        .VF_ACTIVE (VF_ACTIVE)
    )
    u_steer
    (
        .clk, .reset_n,
        .afu_tx_valid, .afu_tx, .afu_tx_ready,
        .pim_tx_a_valid, .pim_tx_a, .pim_tx_a_ready,
        .pim_tx_b_valid, .pim_tx_b, .pim_tx_b_ready
    );

    fim_to_pim_stream_map u_map
    (
        .clk, .reset_n,
        .pim_tx_a_valid, .pim_tx_a, .pim_tx_a_ready,
        .pim_tx_b_valid, .pim_tx_b, .pim_tx_b_ready,
        .fim_tx_a_valid, .fim_tx_a, .fim_tx_a_ready,
        .fim_tx_b_valid, .fim_tx_b, .fim_tx_b_ready,
        .fim_rx_a_valid, .fim_rx_a, .fim_rx_a_ready,
        .fim_rx_b_valid, .fim_rx_b, .fim_rx_b_ready,
        .afu_rx_a_valid, .afu_rx_a, .afu_rx_a_ready,
        .afu_rx_b_valid, .afu_rx_b, .afu_rx_b_ready
    );

    // The tracker watches the subsystem side, where writes and completions are ordered
    wr_commit_tracker
    #(
        .CNT_WIDTH (CNT_WIDTH)
    )
    u_tracker
    (
        .clk, .reset_n,
        .fim_tx_a_valid, .fim_tx_a_ready, .fim_tx_a,
        .fim_rx_b_valid, .fim_rx_b_ready,
        .wr_outstanding
    );

endmodule

//--- tb_host_chan.sv
module tb_host_chan;

    import host_chan_pkg::*;

    localparam logic [2:0]  PF        = 3'd2;
    localparam logic [10:0] VF        = 11'd5;
    localparam logic        VF_ACT    = 1'b1;
    localparam int          CNT_WIDTH = 8;
    // Six tests with a budget of 200 cycles each
    localparam int WATCHDOG_CYCLES = 6 * 200;

    logic                 clk;
    logic                 reset_n;
    logic                 afu_tx_valid;
    pim_beat_t            afu_tx;
    logic                 afu_tx_ready;
    logic                 fim_tx_a_valid;
    fim_beat_t            fim_tx_a;
    logic                 fim_tx_a_ready;
    logic                 fim_tx_b_valid;
    fim_beat_t            fim_tx_b;
    logic                 fim_tx_b_ready;
    logic                 fim_rx_a_valid;
    fim_beat_t            fim_rx_a;
    logic                 fim_rx_a_ready;
    logic                 fim_rx_b_valid;
    fim_beat_t            fim_rx_b;
    logic                 fim_rx_b_ready;
    logic                 afu_rx_a_valid;
    pim_beat_t            afu_rx_a;
    logic                 afu_rx_a_ready;
    logic                 afu_rx_b_valid;
    pim_beat_t            afu_rx_b;
    logic                 afu_rx_b_ready;
    logic [CNT_WIDTH-1:0] wr_outstanding;

    logic [31:0] rng_state;
    string       cur_test;
    int          errors;
    int          checks;

    host_chan_top
    #(
        .PF_NUM    (PF),
        .VF_NUM    (VF),
        .VF_ACTIVE (VF_ACT),
        .CNT_WIDTH (CNT_WIDTH)
    )
    UUT
    (
        .clk, .reset_n,
        .afu_tx_valid, .afu_tx, .afu_tx_ready,
        .fim_tx_a_valid, .fim_tx_a, .fim_tx_a_ready,
        .fim_tx_b_valid, .fim_tx_b, .fim_tx_b_ready,
        .fim_rx_a_valid, .fim_rx_a, .fim_rx_a_ready,
        .fim_rx_b_valid, .fim_rx_b, .fim_rx_b_ready,
        .afu_rx_a_valid, .afu_rx_a, .afu_rx_a_ready,
        .afu_rx_b_valid, .afu_rx_b, .afu_rx_b_ready,
        .wr_outstanding
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Hard stop in case a handshake never completes
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    // Linear congruential generator for payload words
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // Random payload, with a request header in segment 0 on a start beat
    function automatic pim_beat_t make_beat(input tlp_op_e op, input logic sop,
                                            input logic last, input logic dm,
                                            input logic [31:0] keep);
        pim_beat_t    b;
        tlp_req_hdr_t h;
        logic [31:0]  r;
        for (int i = 0; i < TDATA_WIDTH / 32; i++)
        begin
            b.data[i*32 +: 32] = next_rand();
        end
        if (sop)
        begin
            r = next_rand();
            h.fmt_type = op;
            h.length = 10'd1;
            h.tag = r[9:0];
            // Identity fields hold junk that the adapter has to overwrite
            h.pf_num = r[12:10];
            h.vf_num = r[23:13];
            h.vf_active = r[24];
            h.addr = {next_rand(), next_rand()};
            h.reserved = '0;
            b.data[127:0] = h;
        end
        b.keep = keep;
        b.last = last;
        b.user = '0;
        b.user[0].dm_mode = dm;
        b.user[0].sop = sop;
        b.user[0].eop = last;
        return b;
    endfunction

    // What the subsystem should see for a given accelerator beat
    function automatic fim_beat_t expect_fim(input pim_beat_t b);
        fim_beat_t    e;
        tlp_req_hdr_t h;
        e.data = b.data;
        if (b.user[0].sop)
        begin
            h = tlp_req_hdr_t'(b.data[127:0]);
            h.pf_num = PF;
            h.vf_num = VF;
            h.vf_active = VF_ACT;
            e.data[127:0] = h;
        end
        // Each dword is kept whole when its first byte is kept
        for (int w = 0; w < TDATA_WIDTH / 32; w++)
        begin
            e.keep[w*4 +: 4] = b.keep[w*4] ? 4'hf : 4'h0;
        end
        e.last = b.last;
        e.tuser_vendor = {9'd0, b.user[0].dm_mode};
        return e;
    endfunction

    task automatic check_val(input string what, input logic [319:0] exp,
                             input logic [319:0] act);
        checks++;
        assert (exp === act)
        else
        begin
            errors++;
            $display("MISMATCH %s %s: expected %0h actual %0h", cur_test, what, exp, act);
        end
    endtask

    // One accelerator beat, optionally held back by channel A for a few cycles
    task automatic tx_send(input pim_beat_t b, input logic to_b, input int stall);
        fim_beat_t exp;
        fim_beat_t got;
        int        n;
        exp = expect_fim(b);
        @(posedge clk);
        afu_tx_valid <= 1'b1;
        afu_tx <= b;
        if (stall > 0)
        begin
            fim_tx_a_ready <= 1'b0;
        end
        for (n = 0; n < stall; n++)
        begin
            @(negedge clk);
            check_val("stalled ready", 0, afu_tx_ready);
            check_val("stalled beat", exp, fim_tx_a);
        end
        if (stall > 0)
        begin
            @(posedge clk);
            fim_tx_a_ready <= 1'b1;
        end
        n = 0;
        @(negedge clk);
        while (!afu_tx_ready && n < 50)
        begin
            @(negedge clk);
            n++;
        end
        assert (afu_tx_ready)
        else
        begin
            errors++;
            $display("In test %s the accelerator transmit ready never rose", cur_test);
        end
        got = to_b ? fim_tx_b : fim_tx_a;
        check_val("valid", 1, to_b ? fim_tx_b_valid : fim_tx_a_valid);
        check_val("other valid", 0, to_b ? fim_tx_a_valid : fim_tx_b_valid);
        check_val("data", exp.data, got.data);
        check_val("keep", exp.keep, got.keep);
        check_val("last", exp.last, got.last);
        check_val("tuser_vendor", exp.tuser_vendor, got.tuser_vendor);
        // The beat transfers on this edge
        @(posedge clk);
        afu_tx_valid <= 1'b0;
    endtask

    task automatic compare_rx(input logic chan_b, input fim_beat_t f, input logic exp_sop,
                              input logic exp_ready);
        pim_beat_t got;
        got = chan_b ? afu_rx_b : afu_rx_a;
        check_val("rx valid", 1, chan_b ? afu_rx_b_valid : afu_rx_a_valid);
        check_val("rx ready", exp_ready, chan_b ? fim_rx_b_ready : fim_rx_a_ready);
        check_val("rx data", f.data, got.data);
        check_val("rx keep", f.keep, got.keep);
        check_val("rx last", f.last, got.last);
        check_val("dm_mode", f.tuser_vendor[0], got.user[0].dm_mode);
        check_val("sop", exp_sop, got.user[0].sop);
        check_val("eop", f.last, got.user[0].eop);
    endtask

    // One subsystem receive beat, with the accelerator ready low for a cycle when stalled
    task automatic rx_send(input logic chan_b, input fim_beat_t f, input logic exp_sop,
                           input logic stall);
        @(posedge clk);
        if (chan_b)
        begin
            fim_rx_b_valid <= 1'b1;
            fim_rx_b <= f;
            afu_rx_b_ready <= !stall;
        end
        else
        begin
            fim_rx_a_valid <= 1'b1;
            fim_rx_a <= f;
            afu_rx_a_ready <= !stall;
        end
        @(negedge clk);
        compare_rx(chan_b, f, exp_sop, !stall);
        if (stall)
        begin
            @(posedge clk);
            afu_rx_a_ready <= 1'b1;
            afu_rx_b_ready <= 1'b1;
            // Flags must hold while the beat waits
            @(negedge clk);
            compare_rx(chan_b, f, exp_sop, 1'b1);
        end
        @(posedge clk);
        fim_rx_a_valid <= 1'b0;
        fim_rx_b_valid <= 1'b0;
    endtask

    function automatic fim_beat_t make_rx(input logic last, input logic dm,
                                          input logic [31:0] keep);
        fim_beat_t f;
        for (int i = 0; i < TDATA_WIDTH / 32; i++)
        begin
            f.data[i*32 +: 32] = next_rand();
        end
        f.keep = keep;
        f.last = last;
        f.tuser_vendor = {9'd0, dm};
        return f;
    endfunction

    task automatic single_write();
        cur_test = "single_write";
        // Sparse keep with some dwords only partly enabled
        tx_send(make_beat(MEM_WR, 1'b1, 1'b1, 1'b1, 32'h0310_0f21), 1'b0, 0);
    endtask

    task automatic read_then_burst();
        cur_test = "read_then_burst";
        tx_send(make_beat(MEM_RD, 1'b1, 1'b1, 1'b0, '1), 1'b1, 0);
        tx_send(make_beat(MEM_WR, 1'b1, 1'b0, 1'b0, '1), 1'b0, 0);
        tx_send(make_beat(MEM_WR, 1'b0, 1'b0, 1'b0, '1), 1'b0, 0);
        tx_send(make_beat(MEM_WR, 1'b0, 1'b1, 1'b0, 32'h0000_ffff), 1'b0, 0);
    endtask

    task automatic tx_backpressure();
        cur_test = "tx_backpressure";
        tx_send(make_beat(MEM_WR, 1'b1, 1'b1, 1'b1, '1), 1'b0, 4);
    endtask

    task automatic rx_a_packets();
        cur_test = "rx_a_packets";
        rx_send(1'b0, make_rx(1'b0, 1'b1, '1), 1'b1, 1'b1);
        rx_send(1'b0, make_rx(1'b0, 1'b1, '1), 1'b0, 1'b0);
        rx_send(1'b0, make_rx(1'b1, 1'b1, 32'h0000_ffff), 1'b0, 1'b1);
        rx_send(1'b0, make_rx(1'b1, 1'b0, '1), 1'b1, 1'b0);
    endtask

    task automatic rx_b_completions();
        cur_test = "rx_b_completions";
        // Three writes came from the earlier transmit tests
        @(negedge clk);
        check_val("count before", 3, wr_outstanding);
        for (int i = 0; i < 3; i++)
        begin
            rx_send(1'b1, make_rx(1'b1, 1'b0, 32'h0000_000f), 1'b1, i[0]);
        end
        @(negedge clk);
        check_val("count after", 0, wr_outstanding);
    endtask

    task automatic write_count();
        cur_test = "write_count";
        for (int i = 0; i < 4; i++)
        begin
            tx_send(make_beat(MEM_WR, 1'b1, 1'b1, 1'b0, '1), 1'b0, 0);
        end
        @(negedge clk);
        check_val("after writes", 4, wr_outstanding);
        tx_send(make_beat(MEM_RD, 1'b1, 1'b1, 1'b0, '1), 1'b1, 0);
        @(negedge clk);
        check_val("after read", 4, wr_outstanding);
        for (int i = 0; i < 3; i++)
        begin
            rx_send(1'b1, make_rx(1'b1, 1'b0, 32'h0000_000f), 1'b1, 1'b0);
            @(negedge clk);
            check_val("after completion", 3 - i, wr_outstanding);
        end
    endtask

    initial
    begin
        rng_state = 32'd47987;
        errors = 0;
        checks = 0;
        reset_n <= 1'b0;
        afu_tx_valid <= 1'b0;
        afu_tx <= '0;
        fim_tx_a_ready <= 1'b1;
        fim_tx_b_ready <= 1'b1;
        fim_rx_a_valid <= 1'b0;
        fim_rx_a <= '0;
        fim_rx_b_valid <= 1'b0;
        fim_rx_b <= '0;
        afu_rx_a_ready <= 1'b1;
        afu_rx_b_ready <= 1'b1;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        single_write();
        read_then_burst();
        tx_backpressure();
        rx_a_packets();
        rx_b_completions();
        write_count();

        repeat (2) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tlp_tx_steer.sv
module tlp_tx_steer
#(
    parameter logic [2:0]  PF_NUM    = 3'd0,
    parameter logic [10:0] VF_NUM    = 11'd0,
    parameter logic        VF_ACTIVE = 1'b0
)
(
    input  logic                     clk,
    input  logic                     reset_n,

    // Single transmit stream from the accelerator
    input  logic                     afu_tx_valid,
    input  host_chan_pkg::pim_beat_t afu_tx,
    output logic                     afu_tx_ready,

    // Channel A takes everything except memory reads
    output logic                     pim_tx_a_valid,
    output host_chan_pkg::pim_beat_t pim_tx_a,
    input  logic                     pim_tx_a_ready,

    // Channel B takes memory reads so they can pass queued writes
    output logic                     pim_tx_b_valid,
    output host_chan_pkg::pim_beat_t pim_tx_b,
    input  logic                     pim_tx_b_ready
);

    import host_chan_pkg::*;

    localparam int HDR_BITS = $bits(tlp_req_hdr_t);

    tlp_req_hdr_t hdr;
    pim_beat_t    stamped;
    logic         route_b;
    logic         route_b_q;
    logic         in_pkt_q;
    logic         tx_xfer;

    // Header view of segment 0, stamped with this function's identity on a start beat
    always_comb
    begin
        hdr = tlp_req_hdr_t'(afu_tx.data[HDR_BITS-1:0]);
        stamped = afu_tx;
        if (afu_tx.user[0].sop)
        begin
            hdr.pf_num = PF_NUM;
            hdr.vf_num = VF_NUM;
            hdr.vf_active = VF_ACTIVE;
            stamped.data[HDR_BITS-1:0] = hdr;
        end
    end

    // A start beat picks its channel from the header, later beats follow the held route
    assign route_b = in_pkt_q ? route_b_q : (hdr.fmt_type == MEM_RD);

    // Both channels see the same beat, valid marks the one that owns it
    assign pim_tx_a = stamped;
    assign pim_tx_b = stamped;
    assign pim_tx_a_valid = afu_tx_valid && !route_b;
    assign pim_tx_b_valid = afu_tx_valid && route_b;

    // Back-pressure comes only from the chosen channel
    assign afu_tx_ready = route_b ? pim_tx_b_ready : pim_tx_a_ready;
    assign tx_xfer = afu_tx_valid && afu_tx_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            in_pkt_q <= 1'b0;
        end
        else if (tx_xfer)
        begin
            // Stay inside the packet until its last beat has gone
            in_pkt_q <= !afu_tx.last;
        end
    end

    // Route of the packet in flight, taken when its start beat transfers
    always_ff @(posedge clk)
    begin
        if (tx_xfer)
        begin
            route_b_q <= route_b;
        end
    end

    // A new packet must not start before the previous one ended with its last beat
    a_no_sop_in_pkt : assert property (
        @(posedge clk) disable iff (!reset_n)
        (tx_xfer && afu_tx.user[0].sop) |-> !in_pkt_q
    );

endmodule

//--- verilog.f
host_chan_pkg.sv
fim_to_pim_stream_map.sv
tlp_tx_steer.sv
wr_commit_tracker.sv
host_chan_top.sv
tb_host_chan.sv

//--- wr_commit_tracker.sv
module wr_commit_tracker
#(
    parameter int CNT_WIDTH = 8
)
(
    input  logic                     clk,
    input  logic                     reset_n,

    // Transmit A handshake and beat, observed only
    input  logic                     fim_tx_a_valid,
    input  logic                     fim_tx_a_ready,
    input  host_chan_pkg::fim_beat_t fim_tx_a,

    // Receive B handshake, one completion per transfer
    input  logic                     fim_rx_b_valid,
    input  logic                     fim_rx_b_ready,

    // Writes issued but not yet committed
    output logic [CNT_WIDTH-1:0]     wr_outstanding
);

    import host_chan_pkg::*;

    localparam int HDR_BITS = $bits(tlp_req_hdr_t);

    // Subsystem beats carry no start flag, so the tracker follows packet edges itself
    logic         start_q;
    tlp_req_hdr_t hdr;
    logic         tx_xfer;
    logic         wr_inc;
    logic         cpl_dec;

    assign hdr = tlp_req_hdr_t'(fim_tx_a.data[HDR_BITS-1:0]);
    assign tx_xfer = fim_tx_a_valid && fim_tx_a_ready;
    // Count a write once, on its header beat
    assign wr_inc = tx_xfer && start_q && (hdr.fmt_type == MEM_WR);
    assign cpl_dec = fim_rx_b_valid && fim_rx_b_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            start_q <= 1'b1;
            wr_outstanding <= '0;
        end
        else
        begin
            if (tx_xfer)
            begin
                start_q <= fim_tx_a.last;
            end
            // A write and a completion in the same cycle cancel out
            if (wr_inc && !cpl_dec)
            begin
                wr_outstanding <= wr_outstanding + CNT_WIDTH'(1);
            end
            else if (cpl_dec && !wr_inc)
            begin
                wr_outstanding <= wr_outstanding - CNT_WIDTH'(1);
            end
        end
    end

    // Every completion on receive B answers a write already sent on transmit A
    a_no_underflow : assert property (
        @(posedge clk) disable iff (!reset_n)
        (cpl_dec && !wr_inc) |-> (wr_outstanding != '0)
    );

endmodule
